// File: rtl/isa_pkg.sv
package isa_pkg;

    localparam int INST_W = 32;
    localparam int REG_W  = 5;
    localparam int OP_W   = 4;

    // field positions, lsb of each field
    localparam int OP_LSB  = 28;
    localparam int RD_LSB  = 23;
    localparam int RS1_LSB = 18;
    localparam int RS2_LSB = 13;

    typedef enum logic [OP_W-1:0] {
        OP_NOP    = 4'd0,
        OP_ALU    = 4'd1,
        OP_ALUI   = 4'd2,
        OP_LOAD   = 4'd3,
        OP_STORE  = 4'd4,
        OP_BRANCH = 4'd5,
        OP_MUL    = 4'd6,
        OP_DIV    = 4'd7,
        OP_CSR    = 4'd8,
        OP_RDCNT  = 4'd9
    } op_e;

    function automatic op_e inst_op(input logic [INST_W-1:0] inst);
        return op_e'(inst[OP_LSB +: OP_W]);
    endfunction

    function automatic logic [REG_W-1:0] inst_rd(input logic [INST_W-1:0] inst);
        return inst[RD_LSB +: REG_W];
    endfunction

    function automatic logic [REG_W-1:0] inst_rs1(input logic [INST_W-1:0] inst);
        return inst[RS1_LSB +: REG_W];
    endfunction

    function automatic logic [REG_W-1:0] inst_rs2(input logic [INST_W-1:0] inst);
        return inst[RS2_LSB +: REG_W];
    endfunction

    // rdcnt and nop read no register at all
    function automatic logic op_uses_rs1(input op_e op);
        return op inside {OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH,
                          OP_MUL, OP_DIV, OP_CSR};
    endfunction

    // store data and branch compare both come from rs2
    function automatic logic op_uses_rs2(input op_e op);
        return op inside {OP_ALU, OP_STORE, OP_BRANCH, OP_MUL, OP_DIV};
    endfunction

    function automatic logic op_has_rd(input op_e op);
        return op inside {OP_ALU, OP_ALUI, OP_LOAD, OP_MUL, OP_DIV, OP_CSR, OP_RDCNT};
    endfunction

    function automatic logic op_is_simple(input op_e op);
        return op inside {OP_NOP, OP_ALU, OP_ALUI};
    endfunction

    // result arrives late, so a consumer right behind it must wait
    function automatic logic op_is_load_like(input op_e op);
        return op inside {OP_LOAD, OP_RDCNT};
    endfunction

endpackage

// File: rtl/issue_pkg.sv
package issue_pkg;

    localparam int ISSUE_W             = 2;
    localparam int QUEUE_DEPTH_DEFAULT = 8;

    // number of head entries leaving the queue this cycle
    typedef enum logic [ISSUE_W-1:0] {
        ISSUE_NONE = 2'd0,
        ISSUE_ONE  = 2'd1,
        ISSUE_TWO  = 2'd2
    } issue_cnt_e;

    // slot a goes whenever anything issues
    function automatic logic issue_takes_a(input issue_cnt_e cnt);
        return cnt != ISSUE_NONE;
    endfunction

    // slot b only goes as part of a pair
    function automatic logic issue_takes_b(input issue_cnt_e cnt);
        return cnt == ISSUE_TWO;
    endfunction

endpackage

// File: rtl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import isa_pkg::*;
(
    input  logic [INST_W-1:0] i_inst,

    output logic [REG_W-1:0]  o_rd,
    output logic [REG_W-1:0]  o_rs1,
    output logic [REG_W-1:0]  o_rs2,
    output logic              o_uses_rs2,
    output logic              o_writes_rd,
    output logic              o_is_simple,
    output logic              o_is_load_like,
    output logic              o_is_branch,
    output logic              o_is_store
);

    op_e op;

    assign op = inst_op(i_inst);

    // register fields
    assign o_rd  = inst_rd(i_inst);
    assign o_rs2 = inst_rs2(i_inst);

    // an unused rs1 reads as r0, which never matches a live destination
    assign o_rs1 = op_uses_rs1(op) ? inst_rs1(i_inst) : '0;

    assign o_uses_rs2 = op_uses_rs2(op);

    // writes to r0 are discarded, so they create no dependency
    assign o_writes_rd = op_has_rd(op) && (o_rd != '0);

    // class flags for the pairing rules
    assign o_is_simple    = op_is_simple(op);
    assign o_is_load_like = op_is_load_like(op);
    assign o_is_branch    = (op == OP_BRANCH);
    assign o_is_store     = (op == OP_STORE);

endmodule

// File: rtl/inst_queue.sv
`timescale 1ns/1ps

module inst_queue
    import isa_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic              clk,
    input  logic              i_reset,

    input  logic [1:0]        i_fetch_valid,
    input  logic [INST_W-1:0] i_fetch_inst0,
    input  logic [INST_W-1:0] i_fetch_inst1,
    output logic              o_fetch_ready,

    input  logic [1:0]        i_pop_count,
    output logic [1:0]        o_head_valid,
    output logic [INST_W-1:0] o_head_inst_a,
    output logic [INST_W-1:0] o_head_inst_b
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [INST_W-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [CNT_W-1:0]  count_q;

    logic [PTR_W-1:0]  rd_ptr_next1;
    logic [PTR_W-1:0]  wr_ptr_next1;
    logic [1:0]        push_n;

    // pointer advance with wrap, works for any depth
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                                 input logic [1:0]       n);
        logic [PTR_W:0] sum;
        sum = {1'b0, ptr} + (PTR_W + 1)'(n);
        if (sum >= (PTR_W + 1)'(DEPTH)) begin
            sum = sum - (PTR_W + 1)'(DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // fetch side
    ////////////////////////////////////////////////////////////////////////////

    // room for a full pair, so fetch never has to split one
    assign o_fetch_ready = (count_q <= CNT_W'(DEPTH - 2));

    // valid bit 1 implies bit 0
    always_comb begin
        push_n = 2'd0;
        if (o_fetch_ready) begin
            if (i_fetch_valid[1]) begin
                push_n = 2'd2;
            end else if (i_fetch_valid[0]) begin
                push_n = 2'd1;
            end
        end
    end

    assign wr_ptr_next1 = ptr_add(wr_ptr_q, 2'd1);

    always_ff @(posedge clk) begin
        if (push_n != 2'd0) begin
            mem_q[wr_ptr_q] <= i_fetch_inst0;
        end
        if (push_n == 2'd2) begin
            mem_q[wr_ptr_next1] <= i_fetch_inst1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // head side
    ////////////////////////////////////////////////////////////////////////////

    assign rd_ptr_next1 = ptr_add(rd_ptr_q, 2'd1);

    // bit 1 is the oldest entry
    assign o_head_valid[1] = (count_q >= CNT_W'(1));
    assign o_head_valid[0] = (count_q >= CNT_W'(2));
    assign o_head_inst_a   = mem_q[rd_ptr_q];
    assign o_head_inst_b   = mem_q[rd_ptr_next1];

    // pointers and occupancy, push and pop may overlap
    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= ptr_add(rd_ptr_q, i_pop_count);
            wr_ptr_q <= ptr_add(wr_ptr_q, push_n);
            count_q  <= count_q + CNT_W'(push_n) - CNT_W'(i_pop_count);
        end
    end

endmodule

// File: rtl/issue_dispatch.sv
`timescale 1ns/1ps

module issue_dispatch
    import isa_pkg::*;
    import issue_pkg::*;
(
    input  logic             clk,
    input  logic             i_reset,
    input  logic             i_stall,
    input  logic [1:0]       i_head_valid,

    // slot a, the older entry
    input  logic [REG_W-1:0] i_rd_a,
    input  logic [REG_W-1:0] i_rs1_a,
    input  logic [REG_W-1:0] i_rs2_a,
    input  logic             i_uses_rs2_a,
    input  logic             i_writes_rd_a,
    input  logic             i_is_simple_a,
    input  logic             i_is_load_like_a,
    input  logic             i_is_branch_a,

    // slot b
    input  logic [REG_W-1:0] i_rd_b,
    input  logic [REG_W-1:0] i_rs1_b,
    input  logic [REG_W-1:0] i_rs2_b,
    input  logic             i_uses_rs2_b,
    input  logic             i_writes_rd_b,
    input  logic             i_is_load_like_b,
    input  logic             i_is_branch_b,
    input  logic             i_is_store_b,

    output issue_cnt_e       o_issue_count
);

    logic             lock_q;
    logic [REG_W-1:0] lock_rd_q;

    logic             lock_a;
    logic             lock_b;
    logic             raw_ab;
    logic             load_a;
    logic             load_b;

    // true when the given destination is one of the sources in use
    function automatic logic reads_reg(input logic [REG_W-1:0] rd,
                                       input logic [REG_W-1:0] rs1,
                                       input logic [REG_W-1:0] rs2,
                                       input logic             uses_rs2);
        return (rd == rs1) || (uses_rs2 && (rd == rs2));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // hazard terms
    ////////////////////////////////////////////////////////////////////////////

    // load-use against what issued last cycle
    assign lock_a = lock_q && reads_reg(lock_rd_q, i_rs1_a, i_rs2_a, i_uses_rs2_a);
    assign lock_b = lock_q && reads_reg(lock_rd_q, i_rs1_b, i_rs2_b, i_uses_rs2_b);

    // raw inside the pair
    assign raw_ab = i_writes_rd_a && reads_reg(i_rd_a, i_rs1_b, i_rs2_b, i_uses_rs2_b);

    ////////////////////////////////////////////////////////////////////////////
    // issue count, rules in priority order
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (i_stall || !i_head_valid[1]) begin
            o_issue_count = ISSUE_NONE;
        end else if (lock_a) begin
            o_issue_count = ISSUE_NONE;
        end else if (!i_head_valid[0]) begin
            o_issue_count = ISSUE_ONE;
        end else if (lock_b) begin
            o_issue_count = ISSUE_ONE;
        end else if (!i_is_simple_a) begin
            // mul, div, csr, memory and branch leaders go alone
            o_issue_count = ISSUE_ONE;
        end else if (i_is_branch_a && i_is_branch_b) begin
            o_issue_count = ISSUE_ONE;
        end else if (raw_ab) begin
            o_issue_count = ISSUE_ONE;
        end else if (i_is_branch_a && i_is_store_b) begin
            // store must not commit behind an unresolved branch
            o_issue_count = ISSUE_ONE;
        end else begin
            o_issue_count = ISSUE_TWO;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // interlock register
    ////////////////////////////////////////////////////////////////////////////

    // a load-like leader never pairs, so at most one of these is set
    assign load_a = issue_takes_a(o_issue_count) && i_is_load_like_a && i_writes_rd_a;
    assign load_b = issue_takes_b(o_issue_count) && i_is_load_like_b && i_writes_rd_b;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            lock_q <= 1'b0;
        end else begin
            lock_q <= load_a || load_b;
        end
    end

    always_ff @(posedge clk) begin
        lock_rd_q <= load_a ? i_rd_a : i_rd_b;
    end

endmodule

// File: rtl/dual_issue_top.sv
`timescale 1ns/1ps

module dual_issue_top
    import isa_pkg::*;
    import issue_pkg::*;
#(
    parameter int QUEUE_DEPTH = QUEUE_DEPTH_DEFAULT
) (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_stall,

    input  logic [1:0]        i_fetch_valid,
    input  logic [INST_W-1:0] i_fetch_inst0,
    input  logic [INST_W-1:0] i_fetch_inst1,
    output logic              o_fetch_ready,

    output issue_cnt_e        o_issue_count,
    output logic              o_issue_valid_a,
    output logic [INST_W-1:0] o_issue_inst_a,
    output logic              o_issue_valid_b,
    output logic [INST_W-1:0] o_issue_inst_b
);

    logic [1:0]        head_valid;
    logic [INST_W-1:0] head_inst_a;
    logic [INST_W-1:0] head_inst_b;

    // decoded slot a
    logic [REG_W-1:0]  rd_a;
    logic [REG_W-1:0]  rs1_a;
    logic [REG_W-1:0]  rs2_a;
    logic              uses_rs2_a;
    logic              writes_rd_a;
    logic              is_simple_a;
    logic              is_load_like_a;
    logic              is_branch_a;

    // decoded slot b
    logic [REG_W-1:0]  rd_b;
    logic [REG_W-1:0]  rs1_b;
    logic [REG_W-1:0]  rs2_b;
    logic              uses_rs2_b;
    logic              writes_rd_b;
    logic              is_load_like_b;
    logic              is_branch_b;
    logic              is_store_b;

    inst_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) queue_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch_inst0 (i_fetch_inst0),
        .i_fetch_inst1 (i_fetch_inst1),
        .o_fetch_ready (o_fetch_ready),
        .i_pop_count   (o_issue_count),
        .o_head_valid  (head_valid),
        .o_head_inst_a (head_inst_a),
        .o_head_inst_b (head_inst_b)
    );

    // a store leader is already non-simple, so its store flag is not needed
    inst_decoder dec_a_i (
        .i_inst         (head_inst_a),
        .o_rd           (rd_a),
        .o_rs1          (rs1_a),
        .o_rs2          (rs2_a),
        .o_uses_rs2     (uses_rs2_a),
        .o_writes_rd    (writes_rd_a),
        .o_is_simple    (is_simple_a),
        .o_is_load_like (is_load_like_a),
        .o_is_branch    (is_branch_a),
        .o_is_store     ()
    );

    // slot b class only matters through branch, store and load-like
    inst_decoder dec_b_i (
        .i_inst         (head_inst_b),
        .o_rd           (rd_b),
        .o_rs1          (rs1_b),
        .o_rs2          (rs2_b),
        .o_uses_rs2     (uses_rs2_b),
        .o_writes_rd    (writes_rd_b),
        .o_is_simple    (),
        .o_is_load_like (is_load_like_b),
        .o_is_branch    (is_branch_b),
        .o_is_store     (is_store_b)
    );

    issue_dispatch dispatch_i (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_stall          (i_stall),
        .i_head_valid     (head_valid),
        .i_rd_a           (rd_a),
        .i_rs1_a          (rs1_a),
        .i_rs2_a          (rs2_a),
        .i_uses_rs2_a     (uses_rs2_a),
        .i_writes_rd_a    (writes_rd_a),
        .i_is_simple_a    (is_simple_a),
        .i_is_load_like_a (is_load_like_a),
        .i_is_branch_a    (is_branch_a),
        .i_rd_b           (rd_b),
        .i_rs1_b          (rs1_b),
        .i_rs2_b          (rs2_b),
        .i_uses_rs2_b     (uses_rs2_b),
        .i_writes_rd_b    (writes_rd_b),
        .i_is_load_like_b (is_load_like_b),
        .i_is_branch_b    (is_branch_b),
        .i_is_store_b     (is_store_b),
        .o_issue_count    (o_issue_count)
    );

    // issue ports follow the count in the same cycle
    assign o_issue_valid_a = issue_takes_a(o_issue_count);
    assign o_issue_valid_b = issue_takes_b(o_issue_count);
    assign o_issue_inst_a  = head_inst_a;
    assign o_issue_inst_b  = head_inst_b;

endmodule

// File: testbench/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue
    import isa_pkg::*;
    import issue_pkg::*;
();

    localparam int TABLE_LEN  = 40;
    localparam int NUM_PASSES = 2;
    localparam int DEPTH      = QUEUE_DEPTH_DEFAULT;
    localparam int MAX_CYCLES = TABLE_LEN * 8 + 200;

    logic              clk;
    logic              i_reset;
    logic              i_stall;
    logic [1:0]        i_fetch_valid;
    logic [INST_W-1:0] i_fetch_inst0;
    logic [INST_W-1:0] i_fetch_inst1;
    logic              o_fetch_ready;
    issue_cnt_e        o_issue_count;
    logic              o_issue_valid_a;
    logic [INST_W-1:0] o_issue_inst_a;
    logic              o_issue_valid_b;
    logic [INST_W-1:0] o_issue_inst_b;

    logic [INST_W-1:0] prog [TABLE_LEN];
    logic [INST_W-1:0] model_q [$];
    logic              lock_v;
    logic [REG_W-1:0]  lock_rd;
    logic [31:0]       rng;
    int                cycle_cnt = 0;

    dual_issue_top #(
        .QUEUE_DEPTH (DEPTH)
    ) dut_i (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_stall         (i_stall),
        .i_fetch_valid   (i_fetch_valid),
        .i_fetch_inst0   (i_fetch_inst0),
        .i_fetch_inst1   (i_fetch_inst1),
        .o_fetch_ready   (o_fetch_ready),
        .o_issue_count   (o_issue_count),
        .o_issue_valid_a (o_issue_valid_a),
        .o_issue_inst_a  (o_issue_inst_a),
        .o_issue_valid_b (o_issue_valid_b),
        .o_issue_inst_b  (o_issue_inst_b)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [INST_W-1:0] enc(input op_e op, input int rd,
                                              input int rs1, input int rs2);
        return {op, 5'(rd), 5'(rs1), 5'(rs2), 13'd0};
    endfunction

    // register written by a word or r0 when nothing is written
    function automatic logic [REG_W-1:0] dest_of(input logic [INST_W-1:0] w);
        op_e op;
        op = op_e'(w[OP_LSB +: OP_W]);
        if (op inside {OP_NOP, OP_STORE, OP_BRANCH}) begin
            return '0;
        end
        return w[RD_LSB +: REG_W];
    endfunction

    // r0 never creates a dependency
    function automatic logic src_matches(input logic [INST_W-1:0] w,
                                         input logic [REG_W-1:0]  r);
        op_e  op;
        logic hit1;
        logic hit2;
        op   = op_e'(w[OP_LSB +: OP_W]);
        hit1 = (w[RS1_LSB +: REG_W] == r) && !(op inside {OP_NOP, OP_RDCNT});
        hit2 = (w[RS2_LSB +: REG_W] == r)
               && (op inside {OP_ALU, OP_STORE, OP_BRANCH, OP_MUL, OP_DIV});
        return (r != '0) && (hit1 || hit2);
    endfunction

    function automatic issue_cnt_e expect_count(input logic stall);
        op_e op_a;
        op_e op_b;
        if (stall || model_q.size() == 0) begin
            return ISSUE_NONE;
        end
        if (lock_v && src_matches(model_q[0], lock_rd)) begin
            return ISSUE_NONE;
        end
        if (model_q.size() == 1) begin
            return ISSUE_ONE;
        end
        op_a = op_e'(model_q[0][OP_LSB +: OP_W]);
        op_b = op_e'(model_q[1][OP_LSB +: OP_W]);
        // rules 4 to 8 all end in a single issue
        if ((lock_v && src_matches(model_q[1], lock_rd))
                || !(op_a inside {OP_NOP, OP_ALU, OP_ALUI})
                || (op_a == OP_BRANCH && op_b == OP_BRANCH)
                || src_matches(model_q[1], dest_of(model_q[0]))
                || (op_a == OP_BRANCH && op_b == OP_STORE)) begin
            return ISSUE_ONE;
        end
        return ISSUE_TWO;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // clock and run limit
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout: queue did not drain within %0d cycles", MAX_CYCLES);
        $display("Simulation failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          idx;
        int          pass;
        logic        pending;
        logic        exp_ready;
        issue_cnt_e  exp_cnt;
        logic [31:0] r;

        prog = '{
            // load then consumer, load then independent alu and a later consumer
            enc(OP_LOAD, 5, 1, 0),     enc(OP_ALU, 6, 5, 2),
            enc(OP_LOAD, 7, 1, 0),     enc(OP_ALU, 8, 2, 3),
            // raw pair, independent alu pair
            enc(OP_ALUI, 9, 7, 0),     enc(OP_ALU, 10, 9, 1),
            enc(OP_ALU, 11, 1, 2),     enc(OP_ALU, 12, 3, 4),
            // double branch, branch then store
            enc(OP_BRANCH, 0, 1, 2),   enc(OP_BRANCH, 0, 3, 4),
            enc(OP_BRANCH, 0, 5, 6),   enc(OP_STORE, 0, 7, 8),
            // non-simple leaders
            enc(OP_MUL, 13, 1, 2),     enc(OP_ALU, 14, 3, 4),
            enc(OP_CSR, 15, 1, 0),     enc(OP_ALU, 16, 2, 3),
            // counter read then consumer with an unused rs1 field set
            enc(OP_RDCNT, 17, 0, 0),   enc(OP_ALU, 18, 17, 1),
            enc(OP_RDCNT, 19, 18, 0),  enc(OP_STORE, 0, 2, 19),
            enc(OP_ALU, 20, 1, 2),     enc(OP_BRANCH, 0, 20, 3),
            enc(OP_ALU, 21, 1, 2),     enc(OP_STORE, 0, 3, 4),
            enc(OP_DIV, 23, 4, 5),     enc(OP_ALUI, 24, 23, 0),
            // r0 destinations never lock or pair-block
            enc(OP_ALU, 0, 1, 2),      enc(OP_ALU, 25, 0, 0),
            enc(OP_LOAD, 0, 1, 0),     enc(OP_ALU, 26, 0, 3),
            enc(OP_ALUI, 27, 1, 0),    enc(OP_ALUI, 28, 2, 27),
            enc(OP_NOP, 0, 0, 0),      enc(OP_NOP, 0, 0, 0),
            enc(OP_LOAD, 29, 1, 0),    enc(OP_STORE, 0, 29, 2),
            enc(OP_ALU, 30, 1, 2),     enc(OP_LOAD, 31, 30, 0),
            enc(OP_ALU, 3, 31, 1),     enc(OP_ALU, 4, 2, 3)
        };
        // tag each word so a lost or repeated word shows up
        foreach (prog[i]) begin
            prog[i][RS2_LSB-1:0] = 13'(i);
        end

        rng           = 32'h62d1_6cad;
        lock_v        = 1'b0;
        lock_rd       = '0;
        idx           = 0;
        pass          = 0;
        pending       = 1'b0;
        i_reset       = 1'b1;
        i_stall       = 1'b0;
        i_fetch_valid = 2'b00;
        i_fetch_inst0 = '0;
        i_fetch_inst1 = '0;

        repeat (10) @(negedge clk);
        i_reset = 1'b0;
        #1;
        check_value("o_issue_valid_a", o_issue_valid_a, 1'b0);
        check_value("o_issue_valid_b", o_issue_valid_b, 1'b0);
        check_value("o_issue_count", o_issue_count, ISSUE_NONE);
        check_value("o_fetch_ready", o_fetch_ready, 1'b1);

        // pass 0 streams full pairs and later passes use random fetch and stall
        while (pass < NUM_PASSES || model_q.size() != 0) begin
            @(negedge clk);
            rng = xorshift32(rng);
            r   = rng;
            if (!pending) begin
                i_fetch_valid = 2'b00;
                if (pass < NUM_PASSES && (pass == 0 || r[1:0] != 2'd0)) begin
                    if (idx == TABLE_LEN - 1 || (pass != 0 && r[1:0] == 2'd1)) begin
                        i_fetch_valid = 2'b01;
                    end else begin
                        i_fetch_valid = 2'b11;
                    end
                    i_fetch_inst0 = prog[idx];
                    i_fetch_inst1 = prog[(idx + 1) % TABLE_LEN];
                end
            end
            i_stall = (pass != 0) && (r[4:2] == 3'd0);
            #1;

            exp_ready = (model_q.size() <= DEPTH - 2);
            exp_cnt   = expect_count(i_stall);
            check_value("o_fetch_ready", o_fetch_ready, exp_ready);
            check_value("o_issue_count", o_issue_count, exp_cnt);
            check_value("o_issue_valid_a", o_issue_valid_a, exp_cnt != ISSUE_NONE);
            check_value("o_issue_valid_b", o_issue_valid_b, exp_cnt == ISSUE_TWO);
            if (exp_cnt != ISSUE_NONE) begin
                check_value("o_issue_inst_a", o_issue_inst_a, model_q[0]);
            end
            if (exp_cnt == ISSUE_TWO) begin
                check_value("o_issue_inst_b", o_issue_inst_b, model_q[1]);
            end

            // interlock follows the load-like word issued this cycle
            lock_v = 1'b0;
            for (int k = 0; k < int'(exp_cnt); k++) begin
                if (op_e'(model_q[0][OP_LSB +: OP_W]) inside {OP_LOAD, OP_RDCNT}) begin
                    lock_v  = 1'b1;
                    lock_rd = dest_of(model_q[0]);
                end
                void'(model_q.pop_front());
            end

            // a refused offer stays on the fetch bus
            pending = 1'b0;
            if (i_fetch_valid[0] && exp_ready) begin
                model_q.push_back(i_fetch_inst0);
                if (i_fetch_valid[1]) begin
                    model_q.push_back(i_fetch_inst1);
                end
                idx = idx + (i_fetch_valid[1] ? 2 : 1);
                if (idx >= TABLE_LEN) begin
                    idx = 0;
                    pass++;
                end
            end else if (i_fetch_valid[0]) begin
                pending = 1'b1;
            end
        end

        @(negedge clk);
        i_fetch_valid = 2'b00;
        i_stall       = 1'b0;
        #1;
        check_value("o_issue_count", o_issue_count, ISSUE_NONE);
        check_value("o_fetch_ready", o_fetch_ready, 1'b1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: project.f
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/inst_decoder.sv
rtl/inst_queue.sv
rtl/issue_dispatch.sv
rtl/dual_issue_top.sv
testbench/tb_dual_issue.sv

// File: Bender.yml
package:
  name: dual_issue

sources:
  - files:
      - rtl/isa_pkg.sv
      - rtl/issue_pkg.sv
      - rtl/inst_decoder.sv
      - rtl/inst_queue.sv
      - rtl/issue_dispatch.sv
      - rtl/dual_issue_top.sv
  - target: simulation
    files:
      - testbench/tb_dual_issue.sv
